/* hw/mipsCtrlPkg.sv */
`default_nettype none

package mipsCtrlPkg;

  // Major opcodes, MIPS encodings
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_JAL   = 6'h03,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_BLEZ  = 6'h06,
    OP_BGTZ  = 6'h07,
    OP_ADDIU = 6'h09,
    OP_SLTI  = 6'h0a,
    OP_SLTIU = 6'h0b,
    OP_ANDI  = 6'h0c,
    OP_ORI   = 6'h0d,
    OP_XORI  = 6'h0e,
    OP_LUI   = 6'h0f,
    OP_LB    = 6'h20,
    OP_LH    = 6'h21,
    OP_LW    = 6'h23,
    OP_LBU   = 6'h24,
    OP_LHU   = 6'h25,
    OP_SB    = 6'h28,
    OP_SH    = 6'h29,
    OP_SW    = 6'h2b
  } opcodeE;

  // R-type function field
  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_SRL  = 6'h02,
    FN_SRA  = 6'h03,
    FN_JR   = 6'h08,
    FN_JALR = 6'h09,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_NOR  = 6'h27,
    FN_SLT  = 6'h2a,
    FN_SLTU = 6'h2b
  } functE;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT,
    ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_COPYB
  } aluOpE;

  typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_REG, PC_JUMP} pcSelE;
  typedef enum logic [1:0] {DST_RT, DST_RD, DST_R31, DST_NONE} regDstE;
  typedef enum logic [1:0] {RD_UART, RD_ALU, RD_DMEM, RD_COUNTER} rdSelE;
  typedef enum logic [1:0] {SRC_PC, SRC_REG, SRC_FWD, SRC_IMM} aluSrcE;

  typedef struct packed {
    pcSelE  pcSel;
    regDstE regDst;
    rdSelE  rdSel;
    aluSrcE aluSelA;
    aluSrcE aluSelB;
    aluOpE  aluOp;
    logic   regWrite;
    logic   dinSel;
  } dpCtrlT;

  typedef struct packed {
    logic [3:0] imByteSel;
    logic [3:0] dmByteSel;
    logic [1:0] uartSel;
    logic       reUart;
    logic       weUart;
    logic       ctSel;
    logic       ctReset;
  } ioCtrlT;

  // Memory-mapped I/O registers
  localparam logic [31:0] UART_RX_READY_ADDR = 32'h8000_0000;
  localparam logic [31:0] UART_TX_VALID_ADDR = 32'h8000_0004;
  localparam logic [31:0] UART_TX_DATA_ADDR  = 32'h8000_0008;
  localparam logic [31:0] UART_RX_DATA_ADDR  = 32'h8000_000c;
  localparam logic [31:0] CT_CYCLE_ADDR      = 32'h8000_0010;
  localparam logic [31:0] CT_INSTR_ADDR      = 32'h8000_0014;
  localparam logic [31:0] CT_RESET_ADDR      = 32'h8000_0018;

  // UART read mux codes
  localparam logic [1:0] UART_SEL_DATA  = 2'b00;
  localparam logic [1:0] UART_SEL_READY = 2'b01;
  localparam logic [1:0] UART_SEL_VALID = 2'b10;

  // Bit positions inside address[31:28]
  localparam int REGION_DMEM_BIT = 0;
  localparam int REGION_IMEM_BIT = 1;

  function automatic logic isImmOp(input opcodeE op);
    return op inside {OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
  endfunction

  function automatic logic isLoad(input opcodeE op);
    return op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
  endfunction

  function automatic logic isStore(input opcodeE op);
    return op inside {OP_SB, OP_SH, OP_SW};
  endfunction

endpackage

`default_nettype wire

/* hw/aluDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module aluDecode (
  input  mipsCtrlPkg::opcodeE opcode,
  input  mipsCtrlPkg::functE  funct,
  output mipsCtrlPkg::aluOpE  aluOp
);
  import mipsCtrlPkg::*;

  always_comb begin
    aluOp = ALU_ADD;
    if (opcode == OP_RTYPE) begin
      case (funct)
        FN_SLL:  aluOp = ALU_SLL;
        FN_SRL:  aluOp = ALU_SRL;
        FN_SRA:  aluOp = ALU_SRA;
        // Link value passes through on operand B
        FN_JALR: aluOp = ALU_COPYB;
        FN_SUBU: aluOp = ALU_SUB;
        FN_AND:  aluOp = ALU_AND;
        FN_OR:   aluOp = ALU_OR;
        FN_XOR:  aluOp = ALU_XOR;
        FN_NOR:  aluOp = ALU_NOR;
        FN_SLT:  aluOp = ALU_SLT;
        FN_SLTU: aluOp = ALU_SLTU;
        default: aluOp = ALU_ADD;
      endcase
    end else begin
      case (opcode)
        OP_JAL:   aluOp = ALU_COPYB;
        OP_SLTI:  aluOp = ALU_SLT;
        OP_SLTIU: aluOp = ALU_SLTU;
        OP_ANDI:  aluOp = ALU_AND;
        OP_ORI:   aluOp = ALU_OR;
        OP_XORI:  aluOp = ALU_XOR;
        OP_LUI:   aluOp = ALU_LUI;
        // ADDIU, loads and stores all form base plus offset
        default:  aluOp = ALU_ADD;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/controlDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module controlDecode (
  input  logic [31:0]         instr,
  input  logic                branchTaken,
  output mipsCtrlPkg::aluOpE  aluOp,
  output mipsCtrlPkg::pcSelE  pcSel,
  output mipsCtrlPkg::regDstE regDst,
  output mipsCtrlPkg::rdSelE  rdSel,
  output logic                regWrite,
  output logic                memRead,
  output logic                memWrite
);
  import mipsCtrlPkg::*;

  opcodeE     opcode;
  functE      funct;
  logic [4:0] rt;
  logic [4:0] rd;
  logic [4:0] destReg;
  logic       writeReq;

  assign opcode = opcodeE'(instr[31:26]);
  assign funct  = functE'(instr[5:0]);
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];

  aluDecode uAluDecode (
    .opcode(opcode),
    .funct (funct),
    .aluOp (aluOp)
  );

  // Write-back target
  always_comb begin
    regDst   = DST_NONE;
    writeReq = 1'b0;
    if (opcode == OP_RTYPE) begin
      regDst   = DST_RD;
      writeReq = (funct != FN_JR);
    end else if (isImmOp(opcode) || isLoad(opcode)) begin
      regDst   = DST_RT;
      writeReq = 1'b1;
    end else if (opcode == OP_JAL) begin
      regDst   = DST_R31;
      writeReq = 1'b1;
    end
  end

  always_comb begin
    case (regDst)
      DST_RT:  destReg = rt;
      DST_RD:  destReg = rd;
      DST_R31: destReg = 5'd31;
      default: destReg = 5'd0;
    endcase
  end

  // Writes to $zero are dropped, so a NOP is no write at all
  assign regWrite = writeReq && (destReg != 5'd0);

  assign memRead  = isLoad(opcode);
  assign memWrite = isStore(opcode);
  assign rdSel    = memRead ? RD_DMEM : RD_ALU;

  // Branch wins over jumps
  always_comb begin
    if (branchTaken) begin
      pcSel = PC_BRANCH;
    end else if (opcode == OP_J || opcode == OP_JAL) begin
      pcSel = PC_JUMP;
    end else if (opcode == OP_RTYPE && (funct == FN_JR || funct == FN_JALR)) begin
      pcSel = PC_REG;
    end else begin
      pcSel = PC_PLUS4;
    end
  end

endmodule

`default_nettype wire

/* hw/hazardForward.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardForward (
  input  logic [31:0]         instr,
  input  logic [31:0]         prevInstr,
  output mipsCtrlPkg::aluSrcE aluSelA,
  output mipsCtrlPkg::aluSrcE aluSelB,
  output logic                dinSel
);
  import mipsCtrlPkg::*;

  opcodeE     opcode;
  opcodeE     prevOp;
  functE      funct;
  logic [4:0] rs;
  logic [4:0] rt;
  logic [4:0] prodDst;
  logic       isLink;
  logic       isShift;
  logic       matchRs;
  logic       matchRt;

  assign opcode = opcodeE'(instr[31:26]);
  assign prevOp = opcodeE'(prevInstr[31:26]);
  assign funct  = functE'(instr[5:0]);
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];

  // Register written by the previous instruction, zero when there is none
  always_comb begin
    if (prevOp == OP_RTYPE) begin
      prodDst = prevInstr[15:11];
    end else if (isImmOp(prevOp) || isLoad(prevOp)) begin
      prodDst = prevInstr[20:16];
    end else begin
      prodDst = 5'd0;
    end
  end

  assign matchRs = (prodDst != 5'd0) && (rs == prodDst);
  assign matchRt = (prodDst != 5'd0) && (rt == prodDst);

  assign isLink  = (opcode == OP_JAL) || (opcode == OP_RTYPE && funct == FN_JALR);
  assign isShift = (opcode == OP_RTYPE) && (funct inside {FN_SLL, FN_SRL, FN_SRA});

  always_comb begin
    if (isLink) begin
      aluSelA = SRC_PC;
      aluSelB = SRC_PC;
    end else begin
      // Shift amount rides on the immediate path
      if (isShift) aluSelA = SRC_IMM;
      else         aluSelA = matchRs ? SRC_FWD : SRC_REG;

      if (isImmOp(opcode) || isLoad(opcode) || isStore(opcode)) aluSelB = SRC_IMM;
      else aluSelB = matchRt ? SRC_FWD : SRC_REG;
    end
  end

  // Store data comes from rt
  assign dinSel = isStore(opcode) && matchRt;

endmodule

`default_nettype wire

/* hw/memIoDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module memIoDecode (
  input  logic                memRead,
  input  logic                memWrite,
  input  logic [31:0]         aluAddr,
  input  mipsCtrlPkg::opcodeE storeOp,
  output mipsCtrlPkg::ioCtrlT ioCtrl
);
  import mipsCtrlPkg::*;

  logic [3:0] region;
  logic       inDmem;
  logic       inImem;
  logic [3:0] byteMask;

  assign region = aluAddr[31:28];
  // 0011 lands in both regions
  assign inDmem = (region[3:2] == 2'b00) && region[REGION_DMEM_BIT];
  assign inImem = (region[3:2] == 2'b00) && region[REGION_IMEM_BIT];

  // Big-endian lanes, byte 0 is the top lane
  always_comb begin
    case (storeOp)
      OP_SB:   byteMask = 4'b1000 >> aluAddr[1:0];
      OP_SH:   byteMask = 4'b1100 >> {aluAddr[1], 1'b0};
      OP_SW:   byteMask = 4'b1111;
      default: byteMask = 4'b0000;
    endcase
  end

  always_comb begin
    ioCtrl = '0;
    ioCtrl.dmByteSel = (memWrite && inDmem) ? byteMask : 4'b0000;
    ioCtrl.imByteSel = (memWrite && inImem) ? byteMask : 4'b0000;
    ioCtrl.uartSel   = UART_SEL_DATA;

    if (memRead) begin
      case (aluAddr)
        UART_RX_READY_ADDR: ioCtrl.uartSel = UART_SEL_READY;
        UART_TX_VALID_ADDR: ioCtrl.uartSel = UART_SEL_VALID;
        UART_RX_DATA_ADDR:  ioCtrl.reUart  = 1'b1;
        CT_CYCLE_ADDR:      ioCtrl.ctSel   = 1'b0;
        CT_INSTR_ADDR:      ioCtrl.ctSel   = 1'b1;
        default: ;
      endcase
    end

    if (memWrite) begin
      case (aluAddr)
        UART_TX_DATA_ADDR: ioCtrl.weUart  = 1'b1;
        CT_RESET_ADDR:     ioCtrl.ctReset = 1'b1;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
  input  logic                clk,
  input  logic                arstN,
  input  logic [31:0]         instr,
  input  logic                instrValid,
  input  logic [31:0]         aluAddr,
  input  logic                branchTaken,
  output mipsCtrlPkg::dpCtrlT dpCtrl,
  output mipsCtrlPkg::ioCtrlT ioCtrl
);
  import mipsCtrlPkg::*;

  logic [31:0] prevInstr;
  aluOpE       aluOp;
  pcSelE       pcSel;
  regDstE      regDst;
  rdSelE       rdSel;
  aluSrcE      aluSelA;
  aluSrcE      aluSelB;
  logic        regWrite;
  logic        memRead;
  logic        memWrite;
  logic        dinSel;

  // One instruction of history, held while stalled
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      prevInstr <= '0;
    end else if (instrValid) begin
      prevInstr <= instr;
    end
  end

  controlDecode uControlDecode (
    .instr      (instr),
    .branchTaken(branchTaken),
    .aluOp      (aluOp),
    .pcSel      (pcSel),
    .regDst     (regDst),
    .rdSel      (rdSel),
    .regWrite   (regWrite),
    .memRead    (memRead),
    .memWrite   (memWrite)
  );

  hazardForward uHazardForward (
    .instr    (instr),
    .prevInstr(prevInstr),
    .aluSelA  (aluSelA),
    .aluSelB  (aluSelB),
    .dinSel   (dinSel)
  );

  memIoDecode uMemIoDecode (
    .memRead (memRead),
    .memWrite(memWrite),
    .aluAddr (aluAddr),
    .storeOp (opcodeE'(instr[31:26])),
    .ioCtrl  (ioCtrl)
  );

  assign dpCtrl = '{
    pcSel:    pcSel,
    regDst:   regDst,
    rdSel:    rdSel,
    aluSelA:  aluSelA,
    aluSelB:  aluSelB,
    aluOp:    aluOp,
    regWrite: regWrite,
    dinSel:   dinSel
  };

endmodule

`default_nettype wire

/* verif/controlUnit_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnitProperties (
  input logic                clk,
  input logic                arstN,
  input logic [31:0]         instr,
  input logic [31:0]         aluAddr,
  input mipsCtrlPkg::ioCtrlT ioCtrl
);
  import mipsCtrlPkg::*;

  logic storeOp;
  logic overlap;
  logic anyDm;
  logic anyIm;

  assign storeOp = instr[31:26] inside {OP_SB, OP_SH, OP_SW};
  // Top nibble 0011 maps to both memories
  assign overlap = (aluAddr[31:28] == 4'b0011);
  assign anyDm   = (ioCtrl.dmByteSel != 4'd0);
  assign anyIm   = (ioCtrl.imByteSel != 4'd0);

  uartExclusive: assert property (@(posedge clk) disable iff (!arstN)
    !(ioCtrl.weUart && ioCtrl.reUart))
    else $error("UART read and write strobes high together");

  byteSelNeedsStore: assert property (@(posedge clk) disable iff (!arstN)
    (anyDm || anyIm) |-> storeOp)
    else $error("Byte select active without a store");

  oneRegion: assert property (@(posedge clk) disable iff (!arstN)
    (anyDm && anyIm) |-> overlap)
    else $error("Both memories selected outside the overlap region");

endmodule

bind controlUnit controlUnitProperties uControlUnitProperties (
  .clk    (clk),
  .arstN  (arstN),
  .instr  (instr),
  .aluAddr(aluAddr),
  .ioCtrl (ioCtrl)
);

`default_nettype wire

/* verif/controlUnitTb.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb;
  import mipsCtrlPkg::*;

  typedef struct packed {
    logic [31:0] instr;
    logic        valid;
    logic [31:0] addr;
    logic        branch;
    dpCtrlT      expDp;
    ioCtrlT      expIo;
  } rowT;

  logic        clk;
  logic        arstN;
  logic [31:0] instr;
  logic        instrValid;
  logic [31:0] aluAddr;
  logic        branchTaken;
  dpCtrlT      dpCtrl;
  ioCtrlT      ioCtrl;

  rowT rows[$];
  int  errorCount;
  int  checkCount;

  controlUnit u_controlUnit (
    .clk        (clk),
    .arstN      (arstN),
    .instr      (instr),
    .instrValid (instrValid),
    .aluAddr    (aluAddr),
    .branchTaken(branchTaken),
    .dpCtrl     (dpCtrl),
    .ioCtrl     (ioCtrl)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Three rising edges in reset, release on a falling edge
  initial begin
    arstN = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Instruction encoders
  function automatic logic [31:0] rType(input int rs, input int rt, input int rd,
                                        input int sh, input functE fn);
    return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
  endfunction

  function automatic logic [31:0] iType(input opcodeE op, input int rs, input int rt,
                                        input int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  function automatic logic [31:0] jType(input opcodeE op, input int target);
    return {op, target[25:0]};
  endfunction

  function automatic dpCtrlT mkDp(input pcSelE pc, input regDstE dst, input rdSelE rd,
                                  input aluSrcE a, input aluSrcE b, input aluOpE op,
                                  input logic wr, input logic din);
    dpCtrlT d;
    d.pcSel    = pc;
    d.regDst   = dst;
    d.rdSel    = rd;
    d.aluSelA  = a;
    d.aluSelB  = b;
    d.aluOp    = op;
    d.regWrite = wr;
    d.dinSel   = din;
    return d;
  endfunction

  function automatic ioCtrlT mkIo(input logic [3:0] imB, input logic [3:0] dmB,
                                  input logic [1:0] uSel, input logic re, input logic we,
                                  input logic ct, input logic ctr);
    ioCtrlT io;
    io.imByteSel = imB;
    io.dmByteSel = dmB;
    io.uartSel   = uSel;
    io.reUart    = re;
    io.weUart    = we;
    io.ctSel     = ct;
    io.ctReset   = ctr;
    return io;
  endfunction

  task automatic addRow(input logic [31:0] i, input logic v, input logic [31:0] addr,
                        input logic br, input dpCtrlT d, input ioCtrlT io);
    rowT r;
    r.instr  = i;
    r.valid  = v;
    r.addr   = addr;
    r.branch = br;
    r.expDp  = d;
    r.expIo  = io;
    rows.push_back(r);
  endtask

  // Expected values follow the previous valid row
  task automatic buildTable();
    ioCtrlT      noIo;
    dpCtrlT      stDp;
    dpCtrlT      ldDp;
    dpCtrlT      indepDp;
    logic [3:0]  sbMask;
    logic [3:0]  shMask;
    logic [31:0] seed;
    int          off;
    int          k;
    int          a;
    int          b;
    int          d;
    noIo    = '0;
    stDp    = mkDp(PC_PLUS4, DST_NONE, RD_ALU, SRC_REG, SRC_IMM, ALU_ADD, 1'b0, 1'b0);
    ldDp    = mkDp(PC_PLUS4, DST_RT, RD_DMEM, SRC_REG, SRC_IMM, ALU_ADD, 1'b1, 1'b0);
    indepDp = mkDp(PC_PLUS4, DST_RD, RD_ALU, SRC_REG, SRC_REG, ALU_ADD, 1'b1, 1'b0);

    // Write-back, PC select and forwarding chain
    addRow(rType(1, 2, 3, 0, FN_ADDU), 1'b1, 32'h0, 1'b0, indepDp, noIo);
    addRow(iType(OP_ADDIU, 3, 4, 5), 1'b1, 32'h0, 1'b0,
           mkDp(PC_PLUS4, DST_RT, RD_ALU, SRC_FWD, SRC_IMM, ALU_ADD, 1'b1, 1'b0), noIo);
    addRow(rType(1, 4, 5, 0, FN_SUBU), 1'b1, 32'h0, 1'b0,
           mkDp(PC_PLUS4, DST_RD, RD_ALU, SRC_REG, SRC_FWD, ALU_SUB, 1'b1, 1'b0), noIo);
    addRow(jType(OP_JAL, 'h100), 1'b1, 32'h0, 1'b0,
           mkDp(PC_JUMP, DST_R31, RD_ALU, SRC_PC, SRC_PC, ALU_COPYB, 1'b1, 1'b0), noIo);
    addRow(rType(31, 0, 0, 0, FN_JR), 1'b1, 32'h0, 1'b0,
           mkDp(PC_REG, DST_RD, RD_ALU, SRC_REG, SRC_REG, ALU_ADD, 1'b0, 1'b0), noIo);
    addRow(iType(OP_BEQ, 1, 2, 4), 1'b1, 32'h0, 1'b1,
           mkDp(PC_BRANCH, DST_NONE, RD_ALU, SRC_REG, SRC_REG, ALU_ADD, 1'b0, 1'b0), noIo);
    // Taken branch beats the jump
    addRow(jType(OP_J, 'h40), 1'b1, 32'h0, 1'b1,
           mkDp(PC_BRANCH, DST_NONE, RD_ALU, SRC_REG, SRC_REG, ALU_ADD, 1'b0, 1'b0), noIo);
    addRow(rType(0, 5, 6, 2, FN_SLL), 1'b1, 32'h0, 1'b0,
           mkDp(PC_PLUS4, DST_RD, RD_ALU, SRC_IMM, SRC_REG, ALU_SLL, 1'b1, 1'b0), noIo);
    addRow(rType(0, 6, 7, 3, FN_SRA), 1'b1, 32'h0, 1'b0,
           mkDp(PC_PLUS4, DST_RD, RD_ALU, SRC_IMM, SRC_FWD, ALU_SRA, 1'b1, 1'b0), noIo);
    addRow(iType(OP_LUI, 0, 8, 'h1234), 1'b1, 32'h0, 1'b0,
           mkDp(PC_PLUS4, DST_RT, RD_ALU, SRC_REG, SRC_IMM, ALU_LUI, 1'b1, 1'b0), noIo);
    addRow(rType(8, 2, 9, 0, FN_SLT), 1'b1, 32'h0, 1'b0,
           mkDp(PC_PLUS4, DST_RD, RD_ALU, SRC_FWD, SRC_REG, ALU_SLT, 1'b1, 1'b0), noIo);
    addRow(iType(OP_SLTI, 9, 10, 7), 1'b1, 32'h0, 1'b0,
           mkDp(PC_PLUS4, DST_RT, RD_ALU, SRC_FWD, SRC_IMM, ALU_SLT, 1'b1, 1'b0), noIo);
    // Producer at $zero, then a reader of $zero
    addRow(rType(1, 2, 0, 0, FN_ADDU), 1'b1, 32'h0, 1'b0,
           mkDp(PC_PLUS4, DST_RD, RD_ALU, SRC_REG, SRC_REG, ALU_ADD, 1'b0, 1'b0), noIo);
    addRow(rType(0, 0, 11, 0, FN_ADDU), 1'b1, 32'h0, 1'b0, indepDp, noIo);
    addRow(rType(11, 1, 12, 0, FN_ADDU), 1'b1, 32'h0, 1'b0,
           mkDp(PC_PLUS4, DST_RD, RD_ALU, SRC_FWD, SRC_REG, ALU_ADD, 1'b1, 1'b0), noIo);
    // Stalled slot must not replace the history
    addRow(iType(OP_ORI, 1, 13, 'hff), 1'b0, 32'h0, 1'b0,
           mkDp(PC_PLUS4, DST_RT, RD_ALU, SRC_REG, SRC_IMM, ALU_OR, 1'b1, 1'b0), noIo);
    addRow(rType(12, 13, 14, 0, FN_XOR), 1'b1, 32'h0, 1'b0,
           mkDp(PC_PLUS4, DST_RD, RD_ALU, SRC_FWD, SRC_REG, ALU_XOR, 1'b1, 1'b0), noIo);
    addRow(iType(OP_LW, 14, 15, 0), 1'b1, 32'h1000_0000, 1'b0,
           mkDp(PC_PLUS4, DST_RT, RD_DMEM, SRC_FWD, SRC_IMM, ALU_ADD, 1'b1, 1'b0), noIo);
    addRow(iType(OP_SW, 1, 15, 0), 1'b1, 32'h1000_0000, 1'b0,
           mkDp(PC_PLUS4, DST_NONE, RD_ALU, SRC_REG, SRC_IMM, ALU_ADD, 1'b0, 1'b1),
           mkIo(4'h0, 4'hf, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0));

    // Byte lanes per offset and region
    for (off = 0; off < 4; off++) begin
      sbMask = {off == 0, off == 1, off == 2, off == 3};
      shMask = {off < 2, off < 2, off >= 2, off >= 2};
      addRow(iType(OP_SB, 1, 2, off), 1'b1, 32'h1000_0000 + off, 1'b0, stDp,
             mkIo(4'h0, sbMask, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0));
      addRow(iType(OP_SH, 1, 2, off), 1'b1, 32'h2000_0000 + off, 1'b0, stDp,
             mkIo(shMask, 4'h0, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0));
      addRow(iType(OP_SW, 1, 2, off), 1'b1, 32'h3000_0000 + off, 1'b0, stDp,
             mkIo(4'hf, 4'hf, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0));
      addRow(iType(OP_SB, 1, 2, off), 1'b1, 32'h4000_0000 + off, 1'b0, stDp, noIo);
    end

    // Mapped I/O registers
    addRow(iType(OP_LW, 0, 16, 0), 1'b1, 32'h8000_0000, 1'b0, ldDp,
           mkIo(4'h0, 4'h0, 2'd1, 1'b0, 1'b0, 1'b0, 1'b0));
    addRow(iType(OP_LW, 0, 16, 4), 1'b1, 32'h8000_0004, 1'b0, ldDp,
           mkIo(4'h0, 4'h0, 2'd2, 1'b0, 1'b0, 1'b0, 1'b0));
    addRow(iType(OP_LW, 0, 16, 12), 1'b1, 32'h8000_000c, 1'b0, ldDp,
           mkIo(4'h0, 4'h0, 2'd0, 1'b1, 1'b0, 1'b0, 1'b0));
    addRow(iType(OP_LW, 0, 16, 16), 1'b1, 32'h8000_0010, 1'b0, ldDp, noIo);
    addRow(iType(OP_LW, 0, 16, 20), 1'b1, 32'h8000_0014, 1'b0, ldDp,
           mkIo(4'h0, 4'h0, 2'd0, 1'b0, 1'b0, 1'b1, 1'b0));
    addRow(iType(OP_LW, 0, 16, 8), 1'b1, 32'h8000_0008, 1'b0, ldDp, noIo);
    addRow(iType(OP_SW, 0, 2, 8), 1'b1, 32'h8000_0008, 1'b0, stDp,
           mkIo(4'h0, 4'h0, 2'd0, 1'b0, 1'b1, 1'b0, 1'b0));
    addRow(iType(OP_SW, 0, 2, 24), 1'b1, 32'h8000_0018, 1'b0, stDp,
           mkIo(4'h0, 4'h0, 2'd0, 1'b0, 1'b0, 1'b0, 1'b1));
    addRow(iType(OP_SW, 0, 2, 12), 1'b1, 32'h8000_000c, 1'b0, stDp, noIo);

    // Random pairs where no source register matches the producer
    seed = 32'd72214;
    for (k = 0; k < 4; k++) begin
      seed = xorshift32(seed);
      d = seed % 32;
      if (d == 0) d = 1;
      seed = xorshift32(seed);
      a = seed % 32;
      if (a == d) a = d ^ 1;
      seed = xorshift32(seed);
      b = seed % 32;
      if (b == d) b = d ^ 1;
      addRow(rType(0, 0, d, 0, FN_ADDU), 1'b1, 32'h0, 1'b0, indepDp, noIo);
      addRow(rType(a, b, d, 0, FN_ADDU), 1'b1, 32'h0, 1'b0, indepDp, noIo);
    end
  endtask

  task automatic checkReset();
    checkCount++;
    if (dpCtrl.pcSel !== PC_PLUS4) begin
      errorCount++;
      $display("Fail t=%0t pcSel got %0d expected %0d", $time, dpCtrl.pcSel, PC_PLUS4);
    end
    if (dpCtrl.regWrite !== 1'b0) begin
      errorCount++;
      $display("Fail t=%0t regWrite got %b expected 0", $time, dpCtrl.regWrite);
    end
    if (ioCtrl !== '0) begin
      errorCount++;
      $display("Fail t=%0t ioCtrl got %h expected 0", $time, ioCtrl);
    end
  endtask

  task automatic checkOutputs(input int idx, input dpCtrlT expDp, input ioCtrlT expIo);
    checkCount++;
    if (dpCtrl !== expDp) begin
      errorCount++;
      $display("Fail t=%0t row %0d dpCtrl got %h expected %h", $time, idx, dpCtrl, expDp);
    end
    if (ioCtrl !== expIo) begin
      errorCount++;
      $display("Fail t=%0t row %0d ioCtrl got %h expected %h", $time, idx, ioCtrl, expIo);
    end
  endtask

  initial begin
    int waitCount;
    int idx;
    bit timedOut;
    errorCount  = 0;
    checkCount  = 0;
    timedOut    = 1'b0;
    waitCount   = 0;
    instr       = 32'h0;
    instrValid  = 1'b0;
    aluAddr     = 32'h0;
    branchTaken = 1'b0;
    buildTable();

    // Sample 1 ns before each rising edge
    while (arstN !== 1'b1 && !timedOut) begin
      @(negedge clk);
      #4;
      if (arstN === 1'b0) checkReset();
      waitCount++;
      if (waitCount > 20 && arstN !== 1'b1) begin
        timedOut = 1'b1;
        errorCount++;
        $display("Reset was not released within 20 cycles");
      end
    end

    if (!timedOut) begin
      for (idx = 0; idx < rows.size(); idx++) begin
        @(negedge clk);
        instr       = rows[idx].instr;
        instrValid  = rows[idx].valid;
        aluAddr     = rows[idx].addr;
        branchTaken = rows[idx].branch;
        #4;
        checkOutputs(idx, rows[idx].expDp, rows[idx].expIo);
      end
    end

    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
hw/mipsCtrlPkg.sv
hw/aluDecode.sv
hw/controlDecode.sv
hw/hazardForward.sv
hw/memIoDecode.sv
hw/controlUnit.sv
verif/controlUnit_properties.sv
verif/controlUnitTb.sv

/* run.sh */
#!/bin/sh
# Build and run the controlUnit testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps --top-module controlUnitTb \
  -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/VcontrolUnitTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0
